/* ecc_pkg.sv */
package ecc_pkg;

    // ##################################################
    // widths and types
    // ##################################################
    localparam int ECC_DATA_W  = 49;
    localparam int ECC_PAR_W   = 7;
    localparam int ECC_CODE_W  = ECC_DATA_W + ECC_PAR_W;
    localparam int AXIL_DATA_W = 64;
    localparam int AXIL_ADDR_W = 12;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
    localparam int MEM_IDX_W   = AXIL_ADDR_W - 3;   // word index from address bits 3 and up.

    typedef logic [ECC_DATA_W-1:0]  ecc_data_t;
    typedef logic [ECC_PAR_W-1:0]   ecc_par_t;       // check bits, also the syndrome.
    typedef logic [ECC_CODE_W-1:0]  ecc_code_t;      // {check, data}.
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [1:0]             axil_resp_t;
    typedef logic [15:0]            ecc_count_t;
    typedef logic [MEM_IDX_W-1:0]   mem_idx_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;
    localparam axil_resp_t RESP_DECERR = 2'b11;

    // ##################################################
    // address map
    // ##################################################
    localparam axil_addr_t MEM_BASE      = 12'h000;
    localparam axil_addr_t CSR_CTRL      = 12'h800;  // bit 0 is bypass.
    localparam axil_addr_t CSR_INJECT    = 12'h808;
    localparam axil_addr_t CSR_SBIT_CNT  = 12'h810;
    localparam axil_addr_t CSR_DBIT_CNT  = 12'h818;
    localparam axil_addr_t CSR_LAST_MASK = 12'h820;  // read only.

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic      strobe;
        logic      we;
        mem_idx_t  idx;
        ecc_data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic       wr;
        logic       rd;
        axil_addr_t addr;
        axil_data_t wdata;
    } csr_req_t;

    typedef struct packed {
        logic      sbit_err;
        logic      dbit_err;
        ecc_data_t mask;
    } ecc_status_t;

    // hamming check bits, p[6] keeps every data column at odd weight.
    function automatic ecc_par_t ecc_encode(input ecc_data_t d);
        ecc_par_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]);
        p[4] = (^d[25:11]) ^ (^d[48:41]);
        p[5] = ^d[48:26];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47];
        return p;
    endfunction

endpackage

/* ecc_secded_codec.sv */
`timescale 1ns/10ps

module ecc_secded_codec (
    input  ecc_pkg::ecc_data_t   data_in,
    input  ecc_pkg::ecc_par_t    parity_in,
    input  logic                 bypass,
    output ecc_pkg::ecc_data_t   data_out,
    output ecc_pkg::ecc_status_t status
);

    import ecc_pkg::*;

    ecc_par_t  syndrome;
    ecc_data_t corr_mask;
    logic      data_hit;
    logic      par_hit;
    logic      sbit;
    logic      dbit;

    assign syndrome = ecc_encode(data_in) ^ parity_in;

    // ##################################################
    // syndrome decode
    // ##################################################

    // a data column is the code of its one-hot word.
    always_comb begin
        corr_mask = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (syndrome == ecc_encode(ecc_data_t'(1) << i)) begin
                corr_mask[i] = 1'b1;
            end
        end
    end

    assign data_hit = |corr_mask;

    // exactly one syndrome bit set means a flipped check bit.
    assign par_hit = (syndrome != '0) && ((syndrome & (syndrome - ecc_par_t'(1))) == '0);

    assign sbit = !bypass && (data_hit || par_hit);

    // even syndrome weight or no matching column is uncorrectable.
    assign dbit = !bypass && (syndrome != '0) && (!(^syndrome) || !(data_hit || par_hit));

    // ##################################################
    // output
    // ##################################################
    assign data_out = bypass ? data_in : (data_in ^ corr_mask);

    assign status = '{
        sbit_err: sbit,
        dbit_err: dbit,
        mask:     bypass ? '0 : corr_mask
    };

    a_flags_excl: assert final (!(status.sbit_err && status.dbit_err))
        else $error("codec flags single and double error together");

endmodule

/* ecc_mem_array.sv */
`timescale 1ns/10ps

module ecc_mem_array #(
    parameter int MEM_DEPTH = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ecc_pkg::mem_req_t  req,
    input  ecc_pkg::ecc_code_t inject,
    output ecc_pkg::ecc_code_t rd_code
);

    import ecc_pkg::*;

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    ecc_code_t mem [MEM_DEPTH];
    ecc_code_t wr_code;

    // encode on the way in, then apply the error mask.
    assign wr_code = {ecc_encode(req.wdata), req.wdata} ^ inject;

    always_ff @(posedge clk) begin
        if (req.strobe) begin
            if (req.we) begin
                mem[req.idx[IDX_W-1:0]] <= wr_code;
            end else begin
                rd_code <= mem[req.idx[IDX_W-1:0]];   // one cycle read.
            end
        end
    end

    // slave decode must keep requests inside the array.
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        req.strobe |-> (req.idx < MEM_DEPTH))
        else $error("memory request index %0d out of range", req.idx);

endmodule

/* ecc_csr.sv */
`timescale 1ns/10ps

module ecc_csr (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ecc_pkg::csr_req_t    req,
    input  ecc_pkg::ecc_status_t status,
    input  logic                 status_valid,
    output logic                 bypass,
    output ecc_pkg::ecc_code_t   inject,
    output ecc_pkg::axil_data_t  rd_data
);

    import ecc_pkg::*;

    ecc_count_t sbit_cnt;
    ecc_count_t dbit_cnt;
    ecc_data_t  last_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass    <= 1'b0;
            inject    <= '0;
            sbit_cnt  <= '0;
            dbit_cnt  <= '0;
            last_mask <= '0;
        end else begin
            if (req.wr && (req.addr == CSR_CTRL)) begin
                bypass <= req.wdata[0];
            end
            if (req.wr && (req.addr == CSR_INJECT)) begin
                inject <= req.wdata[ECC_CODE_W-1:0];
            end

            // counters saturate, any write clears.
            if (req.wr && (req.addr == CSR_SBIT_CNT)) begin
                sbit_cnt <= '0;
            end else if (status_valid && status.sbit_err && (sbit_cnt != '1)) begin
                sbit_cnt <= sbit_cnt + 1'b1;
            end
            if (req.wr && (req.addr == CSR_DBIT_CNT)) begin
                dbit_cnt <= '0;
            end else if (status_valid && status.dbit_err && (dbit_cnt != '1)) begin
                dbit_cnt <= dbit_cnt + 1'b1;
            end

            if (status_valid && status.sbit_err) begin
                last_mask <= status.mask;   // zero for a check-bit error.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.rd) begin
            case (req.addr)
                CSR_CTRL:      rd_data <= axil_data_t'(bypass);
                CSR_INJECT:    rd_data <= axil_data_t'(inject);
                CSR_SBIT_CNT:  rd_data <= axil_data_t'(sbit_cnt);
                CSR_DBIT_CNT:  rd_data <= axil_data_t'(dbit_cnt);
                CSR_LAST_MASK: rd_data <= axil_data_t'(last_mask);
                default:       rd_data <= '0;
            endcase
        end
    end

endmodule

/* ecc_axil_slave.sv */
`timescale 1ns/10ps

module ecc_axil_slave #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ecc_pkg::axil_req_t   axil_req,
    output ecc_pkg::axil_rsp_t   axil_rsp,
    output ecc_pkg::mem_req_t    mem_req,
    output ecc_pkg::csr_req_t    csr_req,
    input  ecc_pkg::ecc_data_t   mem_rd_data,
    input  ecc_pkg::ecc_status_t mem_status,
    input  ecc_pkg::axil_data_t  csr_rd_data,
    output logic                 status_valid
);

    import ecc_pkg::*;

    typedef enum logic [1:0] {IDLE, WR_RESP, RD_WAIT, RD_RESP} state_t;

    state_t     state;
    logic       wr_go;
    logic       rd_ready;
    logic       rd_go;
    logic       strb_full;
    logic       rd_is_mem;
    logic       rd_is_csr;
    axil_resp_t wr_resp;
    axil_resp_t bresp;
    axil_data_t rdata;
    axil_resp_t rresp;

    function automatic mem_idx_t word_idx(input axil_addr_t a);
        return mem_idx_t'((a - MEM_BASE) >> 3);
    endfunction

    function automatic logic in_mem(input axil_addr_t a);
        return word_idx(a) < MEM_DEPTH;
    endfunction

    function automatic logic in_csr(input axil_addr_t a);
        axil_addr_t al;
        al = {a[AXIL_ADDR_W-1:3], 3'b000};
        return al inside {CSR_CTRL, CSR_INJECT, CSR_SBIT_CNT, CSR_DBIT_CNT, CSR_LAST_MASK};
    endfunction

    // ##################################################
    // handshakes and requests
    // ##################################################
    assign wr_go     = (state == IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_ready  = (state == IDLE) && !wr_go;   // writes win a tie.
    assign rd_go     = rd_ready && axil_req.arvalid;
    assign strb_full = &axil_req.wstrb;

    always_comb begin
        mem_req = '0;
        if (wr_go && in_mem(axil_req.awaddr) && strb_full) begin
            mem_req.strobe = 1'b1;
            mem_req.we     = 1'b1;
            mem_req.idx    = word_idx(axil_req.awaddr);
            mem_req.wdata  = axil_req.wdata[ECC_DATA_W-1:0];
        end else if (rd_go && in_mem(axil_req.araddr)) begin
            mem_req.strobe = 1'b1;
            mem_req.idx    = word_idx(axil_req.araddr);
        end
    end

    always_comb begin
        csr_req       = '0;
        csr_req.wr    = wr_go && in_csr(axil_req.awaddr);
        csr_req.rd    = rd_go && in_csr(axil_req.araddr);
        csr_req.addr  = wr_go ? {axil_req.awaddr[AXIL_ADDR_W-1:3], 3'b000}
                              : {axil_req.araddr[AXIL_ADDR_W-1:3], 3'b000};
        csr_req.wdata = axil_req.wdata;
    end

    always_comb begin
        if (in_mem(axil_req.awaddr)) begin
            wr_resp = strb_full ? RESP_OKAY : RESP_SLVERR;
        end else if (in_csr(axil_req.awaddr)) begin
            wr_resp = RESP_OKAY;
        end else begin
            wr_resp = RESP_DECERR;
        end
    end

    // ##################################################
    // state machine
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            rd_is_mem <= 1'b0;
            rd_is_csr <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_go) begin
                        state <= WR_RESP;
                    end else if (rd_go) begin
                        state     <= RD_WAIT;
                        rd_is_mem <= in_mem(axil_req.araddr);
                        rd_is_csr <= in_csr(axil_req.araddr);
                    end
                end
                WR_RESP: if (axil_req.bready) state <= IDLE;
                RD_WAIT: state <= RD_RESP;   // read data settles here.
                RD_RESP: if (axil_req.rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= wr_resp;
        end
        if (state == RD_WAIT) begin
            if (rd_is_mem) begin
                rdata <= axil_data_t'(mem_rd_data);
                rresp <= mem_status.dbit_err ? RESP_SLVERR : RESP_OKAY;
            end else if (rd_is_csr) begin
                rdata <= csr_rd_data;
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_DECERR;
            end
        end
    end

    assign status_valid = (state == RD_WAIT) && rd_is_mem;

    assign axil_rsp = '{
        awready: wr_go,
        wready:  wr_go,
        bvalid:  state == WR_RESP,
        bresp:   bresp,
        arready: rd_ready,
        rvalid:  state == RD_RESP,
        rdata:   rdata,
        rresp:   rresp
    };

    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid or rdata changed before rready");

endmodule

/* ecc_mem_top.sv */
`timescale 1ns/10ps

module ecc_mem_top #(
    parameter int MEM_DEPTH = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ecc_pkg::axil_req_t axil_req,
    output ecc_pkg::axil_rsp_t axil_rsp
);

    import ecc_pkg::*;

    mem_req_t    mem_req;
    csr_req_t    csr_req;
    ecc_code_t   rd_code;
    ecc_data_t   rd_data;
    ecc_status_t status;
    logic        status_valid;
    logic        bypass;
    ecc_code_t   inject;
    axil_data_t  csr_rd_data;

    ecc_axil_slave #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_ecc_axil_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .mem_req      (mem_req),
        .csr_req      (csr_req),
        .mem_rd_data  (rd_data),
        .mem_status   (status),
        .csr_rd_data  (csr_rd_data),
        .status_valid (status_valid)
    );

    ecc_mem_array #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_ecc_mem_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (mem_req),
        .inject  (inject),
        .rd_code (rd_code)
    );

    // codec sits between the array register and the read data register.
    ecc_secded_codec u_ecc_secded_codec (
        .data_in   (rd_code[ECC_DATA_W-1:0]),
        .parity_in (rd_code[ECC_CODE_W-1:ECC_DATA_W]),
        .bypass    (bypass),
        .data_out  (rd_data),
        .status    (status)
    );

    ecc_csr u_ecc_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (csr_req),
        .status       (status),
        .status_valid (status_valid),
        .bypass       (bypass),
        .inject       (inject),
        .rd_data      (csr_rd_data)
    );

endmodule

/* tb_ecc_mem_top.sv */
`timescale 1ns/10ps

module tb_ecc_mem_top;

    import ecc_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RST_CYCLES       = 4;
    localparam int CYCLES_PER_ENTRY = 20;
    localparam int MAX_ENTRIES      = 64;
    localparam int DEPTH            = 64;

    localparam axil_strb_t STRB_ALL    = '1;
    localparam axil_data_t DATA_MASK   = (64'd1 << ECC_DATA_W) - 64'd1;
    localparam axil_data_t FLIP_DATA   = 64'd1 << 17;
    localparam axil_data_t FLIP_CHECK  = 64'd1 << (ECC_DATA_W + 3);
    localparam axil_data_t FLIP_DOUBLE = (64'd1 << 5) | (64'd1 << 30);
    localparam axil_data_t FLIP_BYPASS = 64'd1 << 40;

    typedef enum {OP_WR, OP_RD, OP_CNT} op_t;

    logic       clk = 1'b0;
    logic       rst_n;
    axil_req_t  req;
    axil_rsp_t  rsp;
    integer     seed;
    logic       table_done = 1'b0;
    int         n_entries = 0;
    int         data_errs = 0;
    int         resp_errs = 0;
    int         count_errs = 0;
    axil_resp_t resp;
    axil_data_t rdata;
    axil_data_t rnd [8];

    string      t_name  [MAX_ENTRIES];
    op_t        t_op    [MAX_ENTRIES];
    axil_addr_t t_addr  [MAX_ENTRIES];
    axil_data_t t_wdata [MAX_ENTRIES];
    axil_strb_t t_strb  [MAX_ENTRIES];
    axil_data_t t_exp   [MAX_ENTRIES];
    axil_resp_t t_resp  [MAX_ENTRIES];

    ecc_mem_top #(
        .MEM_DEPTH (DEPTH)
    ) u_ecc_mem_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (req),
        .axil_rsp (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##################################################
    // bus tasks
    // ##################################################
    task automatic write_bus(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb, output axil_resp_t bresp);
        @(negedge clk);
        req.awaddr  = addr;
        req.wdata   = data;
        req.wstrb   = strb;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        req.bready  = 1'b1;
        #1;
        while (!(rsp.awready && rsp.wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);   // handshake took the edge in between.
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        #1;
        while (!rsp.bvalid) begin
            @(negedge clk);
            #1;
        end
        bresp = rsp.bresp;
        @(negedge clk);
        req.bready = 1'b0;
    endtask

    task automatic read_bus(input axil_addr_t addr, output axil_data_t data,
                            output axil_resp_t rresp);
        @(negedge clk);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = 1'b1;
        #1;
        while (!rsp.arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req.arvalid = 1'b0;
        #1;
        while (!rsp.rvalid) begin
            @(negedge clk);
            #1;
        end
        data  = rsp.rdata;
        rresp = rsp.rresp;
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    // ##################################################
    // compare tasks
    // ##################################################
    task automatic check_data(input string name, input ecc_data_t exp, input axil_data_t act);
        if (act !== axil_data_t'(exp)) begin
            $display("ERR %s: data expected %h actual %h", name, axil_data_t'(exp), act);
            data_errs++;
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
        if (act !== exp) begin
            $display("ERR %s: resp expected %b actual %b", name, exp, act);
            resp_errs++;
        end
    endtask

    task automatic check_count(input string name, input ecc_count_t exp, input ecc_count_t act);
        if (act !== exp) begin
            $display("ERR %s: count expected %0d actual %0d", name, exp, act);
            count_errs++;
        end
    endtask

    task automatic add_entry(input string name, input op_t op, input axil_addr_t addr,
                             input axil_data_t wdata, input axil_strb_t strb,
                             input axil_data_t exp, input axil_resp_t rsp_exp);
        t_name[n_entries]  = name;
        t_op[n_entries]    = op;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_strb[n_entries]  = strb;
        t_exp[n_entries]   = exp;
        t_resp[n_entries]  = rsp_exp;
        n_entries++;
    endtask

    task automatic build_table();
        axil_data_t word;
        seed = 32'hca4e;
        for (int i = 0; i < 8; i++) begin
            word   = {$random(seed), $random(seed)};
            rnd[i] = word & DATA_MASK;
        end
        add_entry("wr_rt0", OP_WR, 12'h000, rnd[0], STRB_ALL, '0, RESP_OKAY);
        add_entry("wr_rt1", OP_WR, 12'h008, rnd[1], STRB_ALL, '0, RESP_OKAY);
        add_entry("wr_rt2", OP_WR, 12'h1f8, rnd[2], STRB_ALL, '0, RESP_OKAY);   // last word.
        add_entry("rd_rt0", OP_RD, 12'h000, '0, STRB_ALL, rnd[0], RESP_OKAY);
        add_entry("rd_rt1", OP_RD, 12'h008, '0, STRB_ALL, rnd[1], RESP_OKAY);
        add_entry("rd_rt2", OP_RD, 12'h1f8, '0, STRB_ALL, rnd[2], RESP_OKAY);
        add_entry("sbit_rt", OP_CNT, CSR_SBIT_CNT, '0, STRB_ALL, 64'd0, RESP_OKAY);
        add_entry("dbit_rt", OP_CNT, CSR_DBIT_CNT, '0, STRB_ALL, 64'd0, RESP_OKAY);
        // single data bit, corrected on read.
        add_entry("inj_data", OP_WR, CSR_INJECT, FLIP_DATA, STRB_ALL, '0, RESP_OKAY);
        add_entry("wr_sb", OP_WR, 12'h010, rnd[3], STRB_ALL, '0, RESP_OKAY);
        add_entry("inj_off_sb", OP_WR, CSR_INJECT, '0, STRB_ALL, '0, RESP_OKAY);
        add_entry("rd_sb", OP_RD, 12'h010, '0, STRB_ALL, rnd[3], RESP_OKAY);
        add_entry("sbit_sb", OP_CNT, CSR_SBIT_CNT, '0, STRB_ALL, 64'd1, RESP_OKAY);
        add_entry("mask_sb", OP_RD, CSR_LAST_MASK, '0, STRB_ALL, FLIP_DATA, RESP_OKAY);
        add_entry("inj_chk", OP_WR, CSR_INJECT, FLIP_CHECK, STRB_ALL, '0, RESP_OKAY);
        add_entry("wr_cb", OP_WR, 12'h018, rnd[4], STRB_ALL, '0, RESP_OKAY);
        add_entry("inj_off_cb", OP_WR, CSR_INJECT, '0, STRB_ALL, '0, RESP_OKAY);
        add_entry("rd_cb", OP_RD, 12'h018, '0, STRB_ALL, rnd[4], RESP_OKAY);
        add_entry("sbit_cb", OP_CNT, CSR_SBIT_CNT, '0, STRB_ALL, 64'd2, RESP_OKAY);
        add_entry("mask_cb", OP_RD, CSR_LAST_MASK, '0, STRB_ALL, '0, RESP_OKAY);
        // two flipped data bits come back uncorrected.
        add_entry("inj_dbl", OP_WR, CSR_INJECT, FLIP_DOUBLE, STRB_ALL, '0, RESP_OKAY);
        add_entry("wr_db", OP_WR, 12'h020, rnd[5], STRB_ALL, '0, RESP_OKAY);
        add_entry("inj_off_db", OP_WR, CSR_INJECT, '0, STRB_ALL, '0, RESP_OKAY);
        add_entry("rd_db", OP_RD, 12'h020, '0, STRB_ALL, rnd[5] ^ FLIP_DOUBLE, RESP_SLVERR);
        add_entry("dbit_db", OP_CNT, CSR_DBIT_CNT, '0, STRB_ALL, 64'd1, RESP_OKAY);
        add_entry("byp_on", OP_WR, CSR_CTRL, 64'd1, STRB_ALL, '0, RESP_OKAY);
        add_entry("inj_byp", OP_WR, CSR_INJECT, FLIP_BYPASS, STRB_ALL, '0, RESP_OKAY);
        add_entry("wr_bp", OP_WR, 12'h028, rnd[6], STRB_ALL, '0, RESP_OKAY);
        add_entry("inj_off_bp", OP_WR, CSR_INJECT, '0, STRB_ALL, '0, RESP_OKAY);
        add_entry("rd_bp", OP_RD, 12'h028, '0, STRB_ALL, rnd[6] ^ FLIP_BYPASS, RESP_OKAY);
        add_entry("sbit_bp", OP_CNT, CSR_SBIT_CNT, '0, STRB_ALL, 64'd2, RESP_OKAY);
        add_entry("dbit_bp", OP_CNT, CSR_DBIT_CNT, '0, STRB_ALL, 64'd1, RESP_OKAY);
        add_entry("clr_sbit", OP_WR, CSR_SBIT_CNT, rnd[7], STRB_ALL, '0, RESP_OKAY);
        add_entry("sbit_clr", OP_CNT, CSR_SBIT_CNT, '0, STRB_ALL, 64'd0, RESP_OKAY);
        add_entry("byp_off", OP_WR, CSR_CTRL, 64'd0, STRB_ALL, '0, RESP_OKAY);
        // decode errors and refused partial write.
        add_entry("rd_unmap", OP_RD, 12'h900, '0, STRB_ALL, '0, RESP_DECERR);
        add_entry("wr_unmap", OP_WR, 12'h900, rnd[7], STRB_ALL, '0, RESP_DECERR);
        add_entry("rd_oor", OP_RD, 12'h200, '0, STRB_ALL, '0, RESP_DECERR);   // past the array.
        add_entry("wr_part", OP_WR, 12'h000, rnd[7], 8'h0f, '0, RESP_SLVERR);
        add_entry("rd_part", OP_RD, 12'h000, '0, STRB_ALL, rnd[0], RESP_OKAY);
    endtask

    // ##################################################
    // main sequence
    // ##################################################
    initial begin
        req   = '0;
        rst_n = 1'b0;
        build_table();
        table_done = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            if (t_op[i] == OP_WR) begin
                write_bus(t_addr[i], t_wdata[i], t_strb[i], resp);
                check_resp(t_name[i], t_resp[i], resp);
            end else begin
                read_bus(t_addr[i], rdata, resp);
                check_resp(t_name[i], t_resp[i], resp);
                if (t_op[i] == OP_CNT) begin
                    check_count(t_name[i], t_exp[i][15:0], rdata[15:0]);
                end else begin
                    check_data(t_name[i], t_exp[i][ECC_DATA_W-1:0], rdata);
                end
            end
        end
        $display("errors: data %0d, resp %0d, count %0d", data_errs, resp_errs, count_errs);
        if ((data_errs + resp_errs + count_errs) == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (table_done);
        #((n_entries * CYCLES_PER_ENTRY + RST_CYCLES) * CLK_PERIOD);
        $display("timeout: a bus transfer did not complete in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* vlog.f */
ecc_pkg.sv
ecc_secded_codec.sv
ecc_mem_array.sv
ecc_csr.sv
ecc_axil_slave.sv
ecc_mem_top.sv
tb_ecc_mem_top.sv

/* Bender.yml */
package:
  name: ecc_mem

sources:
  - ecc_pkg.sv
  - ecc_secded_codec.sv
  - ecc_mem_array.sv
  - ecc_csr.sv
  - ecc_axil_slave.sv
  - ecc_mem_top.sv
  - target: simulation
    files:
      - tb_ecc_mem_top.sv
